/* rename_core.f */
hdl/rename_pkg.sv
hdl/retire_stage.sv
hdl/free_list.sv
hdl/arch_map_table.sv
hdl/spec_map_table.sv
hdl/commit_buffer.sv
hdl/rename_core.sv
dv/rename_core_checker.sv
dv/rename_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= rename_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb
    import rename_pkg::*;
#(
    parameter int unsigned ROB_DEPTH    = 8,
    parameter int unsigned COMMIT_WIDTH = 2
);

    localparam int unsigned CNT_W  = $clog2(COMMIT_WIDTH + 1);
    localparam int          CLK_NS = 20;

    typedef struct {
        logic                 valid;
        rename_req_t          req;
        logic                 cpl_valid;
        logic [ROB_IDX_W-1:0] cpl_idx;
        logic                 flush;
        rename_rsp_t          exp_rsp;
        logic                 exp_stall;
        logic [CNT_W-1:0]     exp_cnt;
    } step_t;

    // reference buffer entry
    typedef struct {
        int            idx;
        logic          done;
        commit_entry_t e;
    } ref_entry_t;

    logic                 clock;
    logic                 reset_i;
    logic                 rename_valid_i;
    rename_req_t          rename_req_i;
    rename_rsp_t          rename_rsp_o;
    logic                 rename_stall_o;
    logic                 complete_valid_i;
    logic [ROB_IDX_W-1:0] complete_idx_i;
    logic                 flush_i;
    logic [CNT_W-1:0]     retire_cnt_o;

    step_t             steps[$];
    logic [PHYS_W-1:0] ref_spec[ARCH_REGS];
    logic [PHYS_W-1:0] ref_arch[ARCH_REGS];
    logic [PHYS_W-1:0] free_q[$];
    ref_entry_t        rob_q[$];
    int                ref_tail;
    logic [31:0]       rng_state = 32'd82;
    bit                table_ready = 1'b0;

    rename_core #(.ROB_DEPTH(ROB_DEPTH), .COMMIT_WIDTH(COMMIT_WIDTH)) dut_i (
        .clock(clock), .reset_i(reset_i),
        .rename_valid_i(rename_valid_i), .rename_req_i(rename_req_i),
        .rename_rsp_o(rename_rsp_o), .rename_stall_o(rename_stall_o),
        .complete_valid_i(complete_valid_i), .complete_idx_i(complete_idx_i),
        .flush_i(flush_i), .retire_cnt_o(retire_cnt_o)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_arch();
        rng_state = xorshift32(rng_state);
        return int'(rng_state[ARCH_W-1:0]);
    endfunction

    task automatic add_step(input int valid, input int wen, input int rd, input int rs1,
                            input int rs2, input int cpl, input int cidx, input int fl);
        step_t st;
        st           = '{default: '0};
        st.valid     = 1'(valid);
        st.req       = '{rd_wen: 1'(wen), rd_arch: ARCH_W'(rd),
                         rs1_arch: ARCH_W'(rs1), rs2_arch: ARCH_W'(rs2)};
        st.cpl_valid = 1'(cpl);
        st.cpl_idx   = ROB_IDX_W'(cidx);
        st.flush     = 1'(fl);
        steps.push_back(st);
    endtask

    task automatic model_reset();
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_spec[i] = PHYS_W'(i);
            ref_arch[i] = PHYS_W'(i);
        end
        for (int i = 0; i < FREE_REGS; i++) begin
            free_q.push_back(PHYS_W'(ARCH_REGS + i));
        end
        ref_tail = 0;
    endtask

    // expected outputs of one cycle, then the state after its edge
    task automatic model_step(input int s);
        int         n_ret;
        int         writers;
        logic       accept;
        ref_entry_t ent;
        steps[s].exp_stall = (free_q.size() == 0) || (rob_q.size() == ROB_DEPTH) || steps[s].flush;
        accept = steps[s].valid && !steps[s].exp_stall;
        steps[s].exp_rsp.rs1_phys = ref_spec[steps[s].req.rs1_arch];
        steps[s].exp_rsp.rs2_phys = ref_spec[steps[s].req.rs2_arch];
        steps[s].exp_rsp.rd_phys  = '0;
        if (steps[s].req.rd_wen && free_q.size() > 0) begin
            steps[s].exp_rsp.rd_phys = free_q[0];
        end
        steps[s].exp_rsp.rob_idx = ROB_IDX_W'(ref_tail);
        n_ret   = 0;
        writers = 0;
        while (!steps[s].flush && n_ret < COMMIT_WIDTH && n_ret < rob_q.size()
               && rob_q[n_ret].done) begin
            writers = writers + int'(rob_q[n_ret].e.rd_wen);
            n_ret++;
        end
        steps[s].exp_cnt = CNT_W'(writers);
        if (steps[s].flush) begin
            // uncommitted destinations go back to the front in program order
            for (int i = rob_q.size() - 1; i >= 0; i--) begin
                if (rob_q[i].e.rd_wen) begin
                    free_q.push_front(rob_q[i].e.new_prf);
                end
            end
            rob_q.delete();
            ref_spec = ref_arch;
            ref_tail = 0;
        end else begin
            for (int i = 0; i < n_ret; i++) begin
                ent = rob_q.pop_front();
                if (ent.e.rd_wen) begin
                    ref_arch[ent.e.rd_arch] = ent.e.new_prf;
                    free_q.push_back(ent.e.old_prf);
                end
            end
            foreach (rob_q[i]) begin
                if (steps[s].cpl_valid && rob_q[i].idx == int'(steps[s].cpl_idx)) begin
                    rob_q[i].done = 1'b1;
                end
            end
            if (accept) begin
                ent.idx       = ref_tail;
                ent.done      = 1'b0;
                ent.e.rd_wen  = steps[s].req.rd_wen;
                ent.e.rd_arch = steps[s].req.rd_arch;
                ent.e.new_prf = steps[s].exp_rsp.rd_phys;
                ent.e.old_prf = ref_spec[steps[s].req.rd_arch];
                if (steps[s].req.rd_wen) begin
                    void'(free_q.pop_front());
                    ref_spec[steps[s].req.rd_arch] = steps[s].exp_rsp.rd_phys;
                end
                rob_q.push_back(ent);
                ref_tail = (ref_tail + 1) % ROB_DEPTH;
            end
        end
    endtask

    task automatic build_table();
        // reset mapping seen by a non-writer
        add_step(1, 0, 0, next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 1, 1, next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 1, 2, next_arch(), next_arch(), 0, 0, 0);
        // readers of freshly renamed registers
        add_step(1, 1, 1, 1, 2, 0, 0, 0);
        add_step(1, 1, 3, 2, 1, 0, 0, 0);
        // completions out of order
        add_step(0, 0, 0, 0, 0, 1, 2, 0);
        add_step(0, 0, 0, 0, 0, 1, 1, 0);
        add_step(0, 0, 0, 0, 0, 1, 4, 0);
        add_step(0, 0, 0, 0, 0, 1, 0, 0);
        add_step(0, 0, 0, 0, 0, 1, 3, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        // drain the free list, wrapping onto returned registers
        for (int i = 0; i < FREE_REGS; i++) begin
            add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        end
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 1, 5, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 1, 7, 0);
        add_step(0, 0, 0, 0, 0, 1, 6, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        // flush hides a ready retirement and a rename
        add_step(0, 0, 0, 0, 0, 1, 0, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 1);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 0, 0, next_arch(), next_arch(), 0, 0, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 1, 1, 0);
        add_step(0, 0, 0, 0, 0, 1, 0, 0);
        add_step(0, 0, 0, 0, 0, 1, 2, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        add_step(1, 1, next_arch(), next_arch(), next_arch(), 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic report_error(input string msg);
        $display("Error %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "mismatch against the reference model");
    endtask

    task automatic check_rsp(input rename_rsp_t got, input rename_rsp_t exp, input int s);
        if (got !== exp) begin
            report_error($sformatf("step %0d rsp %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                s, got.rs1_phys, got.rs2_phys, got.rd_phys, got.rob_idx,
                exp.rs1_phys, exp.rs2_phys, exp.rd_phys, exp.rob_idx));
        end
    endtask

    task automatic check_cnt(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
                             input int s);
        if (got !== exp) begin
            report_error($sformatf("step %0d retire count %0d, expected %0d", s, got, exp));
        end
    endtask

    task automatic check_stall(input logic got, input logic exp, input int s);
        if (got !== exp) begin
            report_error($sformatf("step %0d stall %0b, expected %0b", s, got, exp));
        end
    endtask

    initial begin
        rename_valid_i   = 1'b0;
        rename_req_i     = '0;
        complete_valid_i = 1'b0;
        complete_idx_i   = '0;
        flush_i          = 1'b0;
        reset_i          = 1'b1;
        build_table();
        model_reset();
        foreach (steps[s]) begin
            model_step(s);
        end
        table_ready = 1'b1;
        repeat (3) @(posedge clock);
        #2;
        reset_i = 1'b0;
        foreach (steps[s]) begin
            rename_valid_i   = steps[s].valid;
            rename_req_i     = steps[s].req;
            complete_valid_i = steps[s].cpl_valid;
            complete_idx_i   = steps[s].cpl_idx;
            flush_i          = steps[s].flush;
            // outputs settle well before the next edge
            #10;
            check_stall(rename_stall_o, steps[s].exp_stall, s);
            check_cnt(retire_cnt_o, steps[s].exp_cnt, s);
            if (steps[s].valid && !steps[s].exp_stall) begin
                check_rsp(rename_rsp_o, steps[s].exp_rsp, s);
            end
            @(posedge clock);
            #2;
        end
        $display("TB PASSED");
        $finish;
    end

    // assertions of the bound checker count their failures
    initial begin
        wait (dut_i.u_checker.fail_cnt != 0);
        $display("Assertion in the bound checker failed at %0t ns", $time);
        $display("TB FAILED");
        $fatal(1, "concurrent assertion failed");
    end

    // run length follows the table size
    initial begin
        wait (table_ready);
        #((steps.size() + 3) * CLK_NS + 200);
        $display("Watchdog expired at %0t ns before the stimulus table finished", $time);
        $display("TB FAILED");
        $fatal(1, "simulation timed out");
    end

endmodule

/* dv/rename_core_checker.sv */
`timescale 1ns/1ps

module rename_core_checker
    import rename_pkg::*;
#(
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input logic                                 clock,
    input logic                                 reset_i,
    input logic                                 flush_i,
    input logic                                 rename_valid_i,
    input rename_req_t                          req_i,
    input rename_rsp_t                          rsp_i,
    input logic                                 stall_i,
    input logic [$clog2(COMMIT_WIDTH+1)-1:0]    retire_cnt_i
);

    logic alloc;

    // number of failed assertions
    int unsigned fail_cnt = 0;

    assign alloc = rename_valid_i & ~stall_i & req_i.rd_wen;

    // retirement is masked while the core recovers
    a_flush_no_retire: assert property (@(posedge clock) disable iff (reset_i)
        flush_i |-> (retire_cnt_i == '0))
        else begin
            fail_cnt++;
            $error("retire count nonzero in a flush cycle");
        end

    a_flush_stall: assert property (@(posedge clock) disable iff (reset_i)
        flush_i |-> stall_i)
        else begin
            fail_cnt++;
            $error("rename not stalled in a flush cycle");
        end

    // a register taken from the free list is not live in the spec map
    a_fresh_alloc: assert property (@(posedge clock) disable iff (reset_i)
        alloc |-> (rsp_i.rd_phys != rsp_i.rs1_phys) && (rsp_i.rd_phys != rsp_i.rs2_phys))
        else begin
            fail_cnt++;
            $error("allocated register %0d is still mapped", rsp_i.rd_phys);
        end

endmodule

bind rename_core rename_core_checker #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_checker (
    .clock(clock), .reset_i(reset_i), .flush_i(flush_i), .rename_valid_i(rename_valid_i),
    .req_i(rename_req_i), .rsp_i(rename_rsp_o), .stall_i(rename_stall_o),
    .retire_cnt_i(retire_cnt_o)
);

/* hdl/rename_core.sv */
`timescale 1ns/1ps

module rename_core
    import rename_pkg::*;
#(
    parameter int unsigned ROB_DEPTH    = 8,
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input  logic                                 clock,
    input  logic                                 reset_i,

    input  logic                                 rename_valid_i,
    input  rename_req_t                          rename_req_i,
    output rename_rsp_t                          rename_rsp_o,
    output logic                                 rename_stall_o,

    input  logic                                 complete_valid_i,
    input  logic [ROB_IDX_W-1:0]                 complete_idx_i,

    input  logic                                 flush_i,
    output logic [$clog2(COMMIT_WIDTH+1)-1:0]    retire_cnt_o
);

    logic                                  accept;
    logic                                  free_empty;
    logic                                  rob_full;
    logic [PHYS_W-1:0]                     head_reg;
    logic [PHYS_W-1:0]                     old_phys;
    logic [ROB_IDX_W-1:0]                  tail_idx;
    map_write_t                            spec_write;
    commit_entry_t                         push_entry;
    logic [COMMIT_WIDTH-1:0]               commit_valid;
    commit_entry_t [COMMIT_WIDTH-1:0]      commit_entry;
    map_write_t [COMMIT_WIDTH-1:0]         amt_write;
    logic [COMMIT_WIDTH-1:0]               free_valid;
    logic [COMMIT_WIDTH-1:0][PHYS_W-1:0]   free_reg;
    logic [ARCH_REGS-1:0][PHYS_W-1:0]      arch_map;

    // flush blocks renaming for its cycle
    assign rename_stall_o = free_empty | rob_full | flush_i;
    assign accept         = rename_valid_i & ~rename_stall_o;

    assign rename_rsp_o.rd_phys = rename_req_i.rd_wen ? head_reg : '0;
    assign rename_rsp_o.rob_idx = tail_idx;

    assign spec_write.valid = accept & rename_req_i.rd_wen;
    assign spec_write.arch  = rename_req_i.rd_arch;
    assign spec_write.phys  = head_reg;

    assign push_entry.rd_wen  = rename_req_i.rd_wen;
    assign push_entry.rd_arch = rename_req_i.rd_arch;
    assign push_entry.new_prf = rename_rsp_o.rd_phys;
    assign push_entry.old_prf = old_phys;

    spec_map_table u_spec_map (
        .clock(clock), .reset_i(reset_i), .flush_i(flush_i),
        .rs1_arch_i(rename_req_i.rs1_arch), .rs2_arch_i(rename_req_i.rs2_arch),
        .rd_arch_i(rename_req_i.rd_arch),
        .rs1_phys_o(rename_rsp_o.rs1_phys), .rs2_phys_o(rename_rsp_o.rs2_phys),
        .old_phys_o(old_phys), .map_write_i(spec_write), .arch_map_i(arch_map)
    );

    free_list #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_free_list (
        .clock(clock), .reset_i(reset_i), .flush_i(flush_i),
        .alloc_i(accept & rename_req_i.rd_wen), .head_reg_o(head_reg), .empty_o(free_empty),
        .free_valid_i(free_valid), .free_reg_i(free_reg), .retire_cnt_i(retire_cnt_o)
    );

    commit_buffer #(.ROB_DEPTH(ROB_DEPTH), .COMMIT_WIDTH(COMMIT_WIDTH)) u_commit_buffer (
        .clock(clock), .reset_i(reset_i), .flush_i(flush_i),
        .push_i(accept), .push_entry_i(push_entry), .tail_idx_o(tail_idx), .full_o(rob_full),
        .complete_valid_i(complete_valid_i), .complete_idx_i(complete_idx_i),
        .commit_valid_o(commit_valid), .commit_entry_o(commit_entry)
    );

    retire_stage #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_retire_stage (
        .flush_i(flush_i), .commit_valid_i(commit_valid), .commit_entry_i(commit_entry),
        .amt_write_o(amt_write), .free_valid_o(free_valid), .free_reg_o(free_reg),
        .retire_cnt_o(retire_cnt_o)
    );

    arch_map_table #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_arch_map (
        .clock(clock), .reset_i(reset_i), .amt_write_i(amt_write), .arch_map_o(arch_map)
    );

endmodule

/* hdl/commit_buffer.sv */
`timescale 1ns/1ps

module commit_buffer
    import rename_pkg::*;
#(
    parameter int unsigned ROB_DEPTH    = 8,
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input  logic                                 clock,
    input  logic                                 reset_i,
    input  logic                                 flush_i,

    // allocation in program order
    input  logic                                 push_i,
    input  commit_entry_t                        push_entry_i,
    output logic [ROB_IDX_W-1:0]                 tail_idx_o,
    output logic                                 full_o,

    // completions from execution
    input  logic                                 complete_valid_i,
    input  logic [ROB_IDX_W-1:0]                 complete_idx_i,

    // oldest completed run, handed to retirement
    output logic [COMMIT_WIDTH-1:0]              commit_valid_o,
    output commit_entry_t [COMMIT_WIDTH-1:0]     commit_entry_o
);

    localparam int unsigned PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(ROB_DEPTH + 1);
    localparam int unsigned POP_W = $clog2(COMMIT_WIDTH + 1);

    commit_entry_t [ROB_DEPTH-1:0] entries_q;
    logic [ROB_DEPTH-1:0]          done_q;
    logic [PTR_W-1:0]              head_q;
    logic [PTR_W-1:0]              tail_q;
    logic [CNT_W-1:0]              count_q;

    logic [COMMIT_WIDTH-1:0][PTR_W-1:0] lane_idx;
    logic                               run;
    logic [POP_W-1:0]                   pop_cnt;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] ptr,
                                                  input int unsigned n);
        int unsigned sum;
        sum = ptr + n;
        if (sum >= ROB_DEPTH) begin
            sum = sum - ROB_DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    assign tail_idx_o = ROB_IDX_W'(tail_q);
    assign full_o     = (count_q == CNT_W'(ROB_DEPTH));

    // a lane retires only if every older lane does too
    always_comb begin
        run     = ~flush_i;
        pop_cnt = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            lane_idx[i]       = wrap_add(head_q, i);
            commit_entry_o[i] = entries_q[lane_idx[i]];
            run               = run & (CNT_W'(i) < count_q) & done_q[lane_idx[i]];
            commit_valid_o[i] = run;
            pop_cnt           = pop_cnt + POP_W'(run);
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i || flush_i) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (complete_valid_i && (32'(complete_idx_i) < ROB_DEPTH)) begin
                done_q[complete_idx_i[PTR_W-1:0]] <= 1'b1;
            end
            if (push_i) begin
                entries_q[tail_q] <= push_entry_i;
                done_q[tail_q]    <= 1'b0;
                tail_q            <= wrap_add(tail_q, 1);
            end
            head_q  <= wrap_add(head_q, pop_cnt);
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_cnt);
        end
    end

endmodule

/* hdl/spec_map_table.sv */
`timescale 1ns/1ps

module spec_map_table
    import rename_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset_i,
    input  logic                                 flush_i,

    // lookups for the instruction being renamed
    input  logic [ARCH_W-1:0]                    rs1_arch_i,
    input  logic [ARCH_W-1:0]                    rs2_arch_i,
    input  logic [ARCH_W-1:0]                    rd_arch_i,
    output logic [PHYS_W-1:0]                    rs1_phys_o,
    output logic [PHYS_W-1:0]                    rs2_phys_o,
    output logic [PHYS_W-1:0]                    old_phys_o,

    // new destination mapping
    input  map_write_t                           map_write_i,

    // committed map to reload from
    input  logic [ARCH_REGS-1:0][PHYS_W-1:0]     arch_map_i
);

    logic [ARCH_REGS-1:0][PHYS_W-1:0] map_q;

    // reads see the table before this cycle's write
    assign rs1_phys_o = map_q[rs1_arch_i];
    assign rs2_phys_o = map_q[rs2_arch_i];

    // previous owner of rd, freed when this writer retires
    assign old_phys_o = map_q[rd_arch_i];

    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PHYS_W'(i);
            end
        end else if (flush_i) begin
            // drop all speculative renames
            map_q <= arch_map_i;
        end else if (map_write_i.valid) begin
            map_q[map_write_i.arch] <= map_write_i.phys;
        end
    end

endmodule

/* hdl/arch_map_table.sv */
`timescale 1ns/1ps

module arch_map_table
    import rename_pkg::*;
#(
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input  logic                                 clock,
    input  logic                                 reset_i,

    // writes from retirement, one per lane
    input  map_write_t [COMMIT_WIDTH-1:0]        amt_write_i,

    // whole committed map, for flush recovery
    output logic [ARCH_REGS-1:0][PHYS_W-1:0]     arch_map_o
);

    logic [ARCH_REGS-1:0][PHYS_W-1:0] map_q;

    assign arch_map_o = map_q;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            // identity mapping out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PHYS_W'(i);
            end
        end else begin
            // later lanes are younger, so they are applied last
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (amt_write_i[i].valid) begin
                    map_q[amt_write_i[i].arch] <= amt_write_i[i].phys;
                end
            end
        end
    end

endmodule

/* hdl/free_list.sv */
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
#(
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input  logic                                  clock,
    input  logic                                  reset_i,
    input  logic                                  flush_i,

    // allocation at the speculative head
    input  logic                                  alloc_i,
    output logic [PHYS_W-1:0]                     head_reg_o,
    output logic                                  empty_o,

    // registers returned by retirement
    input  logic [COMMIT_WIDTH-1:0]               free_valid_i,
    input  logic [COMMIT_WIDTH-1:0][PHYS_W-1:0]   free_reg_i,
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0]     retire_cnt_i
);

    // one slot per physical register, so pointers wrap by themselves
    logic [PHYS_REGS-1:0][PHYS_W-1:0] slots_q;

    logic [PHYS_W-1:0] spec_head_q;
    logic [PHYS_W-1:0] commit_head_q;
    logic [PHYS_W-1:0] tail_q;

    logic [COMMIT_WIDTH-1:0][PHYS_W-1:0] wr_idx;
    logic [PHYS_W-1:0]                   tail_next;

    assign head_reg_o = slots_q[spec_head_q];

    // never more than FREE_REGS live slots, so equal pointers mean empty
    assign empty_o = (spec_head_q == tail_q);

    // frees pack in lane order behind the tail
    always_comb begin
        tail_next = tail_q;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            wr_idx[i] = tail_next;
            if (free_valid_i[i]) begin
                tail_next = tail_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                if (i < FREE_REGS) begin
                    slots_q[i] <= PHYS_W'(ARCH_REGS + i);
                end else begin
                    slots_q[i] <= '0;
                end
            end
            spec_head_q   <= '0;
            commit_head_q <= '0;
            tail_q        <= PHYS_W'(FREE_REGS);
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (free_valid_i[i]) begin
                    slots_q[wr_idx[i]] <= free_reg_i[i];
                end
            end
            tail_q        <= tail_next;
            commit_head_q <= commit_head_q + PHYS_W'(retire_cnt_i);

            // flush gives back everything allocated past the committed point
            if (flush_i) begin
                spec_head_q <= commit_head_q;
            end else if (alloc_i) begin
                spec_head_q <= spec_head_q + 1'b1;
            end
        end
    end

endmodule

/* hdl/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage
    import rename_pkg::*;
#(
    parameter int unsigned COMMIT_WIDTH = 2
)(
    input  logic                                     flush_i,

    // oldest completed entries from the commit buffer
    input  logic [COMMIT_WIDTH-1:0]                  commit_valid_i,
    input  commit_entry_t [COMMIT_WIDTH-1:0]         commit_entry_i,

    // committed map writes
    output map_write_t [COMMIT_WIDTH-1:0]            amt_write_o,

    // returns to the free list
    output logic [COMMIT_WIDTH-1:0]                  free_valid_o,
    output logic [COMMIT_WIDTH-1:0][PHYS_W-1:0]      free_reg_o,

    // number of retiring writers
    output logic [$clog2(COMMIT_WIDTH+1)-1:0]        retire_cnt_o
);

    localparam int unsigned CNT_W = $clog2(COMMIT_WIDTH + 1);

    logic [COMMIT_WIDTH-1:0] fire;

    // only lanes that write a register touch the maps
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            fire[i] = commit_valid_i[i] & commit_entry_i[i].rd_wen & ~flush_i;
        end
    end

    always_comb begin
        retire_cnt_o = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            amt_write_o[i].valid = fire[i];
            amt_write_o[i].arch  = commit_entry_i[i].rd_arch;
            amt_write_o[i].phys  = commit_entry_i[i].new_prf;

            // the old mapping is dead once the writer retires
            free_valid_o[i] = fire[i];
            free_reg_o[i]   = commit_entry_i[i].old_prf;

            retire_cnt_o = retire_cnt_o + CNT_W'(fire[i]);
        end
    end

endmodule

/* hdl/rename_pkg.sv */
package rename_pkg;

    // register file sizes
    localparam int unsigned ARCH_REGS = 8;
    localparam int unsigned PHYS_REGS = 16;
    localparam int unsigned ARCH_W    = 3;
    localparam int unsigned PHYS_W    = 4;

    // registers that are not mapped after reset
    localparam int unsigned FREE_REGS = PHYS_REGS - ARCH_REGS;

    // rob index as seen outside, covers depths up to 16
    localparam int unsigned ROB_IDX_W = 4;

    typedef struct packed {
        logic              rd_wen;
        logic [ARCH_W-1:0] rd_arch;
        logic [ARCH_W-1:0] rs1_arch;
        logic [ARCH_W-1:0] rs2_arch;
    } rename_req_t;

    typedef struct packed {
        logic [PHYS_W-1:0]    rs1_phys;
        logic [PHYS_W-1:0]    rs2_phys;
        logic [PHYS_W-1:0]    rd_phys;
        logic [ROB_IDX_W-1:0] rob_idx;
    } rename_rsp_t;

    // one in-flight instruction as kept by the commit buffer
    typedef struct packed {
        logic              rd_wen;
        logic [ARCH_W-1:0] rd_arch;
        logic [PHYS_W-1:0] new_prf;
        logic [PHYS_W-1:0] old_prf;
    } commit_entry_t;

    // map write, used for both the speculative and the committed map
    typedef struct packed {
        logic              valid;
        logic [ARCH_W-1:0] arch;
        logic [PHYS_W-1:0] phys;
    } map_write_t;

endpackage
